//--- src/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported RV32I subset
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic {
        id_sel_regfile,
        id_sel_wb
    } id_fwd_sel_t;

    typedef enum logic [1:0] {
        ex_sel_id_ex,
        ex_sel_mem,
        ex_sel_wb
    } ex_fwd_sel_t;

    typedef struct packed {
        word_t pc;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1_s;
        reg_idx_t rs2_s;
        word_t    rs1_v;
        word_t    rs2_v;
        word_t    imm;
        reg_idx_t rd;
        logic     rd_we;
        alu_op_t  alu_op;
        logic     a_pc;
        logic     b_imm;
        logic     is_load;
        logic     is_store;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu;
        word_t    store_data;
        reg_idx_t rd;
        logic     rd_we;
        logic     is_load;
        logic     is_store;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    alu;
        reg_idx_t rd;
        logic     rd_we;
        logic     is_load;
    } mem_wb_t;

endpackage

//--- src/fwd_if.sv
`timescale 1ns/1ns

interface fwd_if;

    rv32i_pkg::id_fwd_sel_t id_rs1_sel;
    rv32i_pkg::id_fwd_sel_t id_rs2_sel;
    rv32i_pkg::ex_fwd_sel_t ex_rs1_sel;
    rv32i_pkg::ex_fwd_sel_t ex_rs2_sel;
    logic                   stall;

    modport ctrl (
        output id_rs1_sel,
        output id_rs2_sel,
        output ex_rs1_sel,
        output ex_rs2_sel,
        output stall
    );

    modport id (
        input id_rs1_sel,
        input id_rs2_sel,
        input stall
    );

    modport ex (
        input ex_rs1_sel,
        input ex_rs2_sel
    );

endinterface

//--- src/if_stage.sv
`timescale 1ns/1ns

module if_stage #(
    parameter rv32i_pkg::word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               pc_en,
    output rv32i_pkg::word_t   imem_addr,
    output logic [3:0]         imem_rmask,
    output rv32i_pkg::if_id_t  if_id
);

    rv32i_pkg::word_t pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (pc_en) begin
            pc <= pc + 32'd4;
        end
    end

    // a fetch is requested on every cycle out of reset
    assign imem_addr  = pc;
    assign imem_rmask = {4{~rst}};

    assign if_id.pc    = pc;
    assign if_id.valid = ~rst;

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::if_id_t   if_id,
    input  rv32i_pkg::word_t    imem_rdata,
    input  logic                imem_resp,
    input  rv32i_pkg::reg_idx_t wb_rd_s,
    input  rv32i_pkg::word_t    wb_rd_v,
    input  logic                wb_regf_we,
    output rv32i_pkg::reg_idx_t rs1_s,
    output rv32i_pkg::reg_idx_t rs2_s,
    fwd_if.id                   fwd,
    output rv32i_pkg::id_ex_t   id_ex
);

    rv32i_pkg::word_t  regs [1:31];
    rv32i_pkg::word_t  held_inst;
    logic              replay;
    rv32i_pkg::word_t  inst;
    logic              inst_ok;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt;
    logic              known;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              ok;
    rv32i_pkg::id_ex_t dec;
    rv32i_pkg::word_t  rs1_v;
    rv32i_pkg::word_t  rs2_v;

    function automatic rv32i_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001:  return rv32i_pkg::alu_sll;
            3'b010:  return rv32i_pkg::alu_slt;
            3'b011:  return rv32i_pkg::alu_sltu;
            3'b100:  return rv32i_pkg::alu_xor;
            3'b101:  return sub_sra ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110:  return rv32i_pkg::alu_or;
            default: return rv32i_pkg::alu_and;
        endcase
    endfunction

    // the fetch port has already moved on during a stall, so the word
    // in decode is kept here and replayed on the following cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            replay <= 1'b0;
        end else begin
            replay <= fwd.stall;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd.stall) begin
            held_inst <= inst;
        end
    end

    assign inst    = replay ? held_inst : imem_rdata;
    assign inst_ok = replay | imem_resp;
    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign alt     = inst[30];

    always_comb begin
        dec      = '0;
        known    = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv32i_pkg::op_lui: begin
                known       = 1'b1;
                dec.rd_we   = 1'b1;
                dec.alu_op  = rv32i_pkg::alu_pass_b;
                dec.b_imm   = 1'b1;
                dec.imm     = {inst[31:12], 12'b0};
            end
            rv32i_pkg::op_auipc: begin
                known       = 1'b1;
                dec.rd_we   = 1'b1;
                dec.alu_op  = rv32i_pkg::alu_add;
                dec.a_pc    = 1'b1;
                dec.b_imm   = 1'b1;
                dec.imm     = {inst[31:12], 12'b0};
            end
            rv32i_pkg::op_load: begin
                // only full-word loads
                known       = (funct3 == 3'b010);
                uses_rs1    = 1'b1;
                dec.rd_we   = 1'b1;
                dec.alu_op  = rv32i_pkg::alu_add;
                dec.b_imm   = 1'b1;
                dec.is_load = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
            end
            rv32i_pkg::op_store: begin
                known        = (funct3 == 3'b010);
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.alu_op   = rv32i_pkg::alu_add;
                dec.b_imm    = 1'b1;
                dec.is_store = 1'b1;
                dec.imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv32i_pkg::op_imm: begin
                known      = 1'b1;
                uses_rs1   = 1'b1;
                dec.rd_we  = 1'b1;
                dec.alu_op = alu_decode(funct3, alt && (funct3 == 3'b101));
                dec.b_imm  = 1'b1;
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
            end
            rv32i_pkg::op_reg: begin
                known      = 1'b1;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                dec.rd_we  = 1'b1;
                dec.alu_op = alu_decode(funct3, alt);
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign ok    = if_id.valid && inst_ok && known;
    // unused sources read as x0 so they never match a producer
    assign rs1_s = (ok && uses_rs1) ? inst[19:15] : '0;
    assign rs2_s = (ok && uses_rs2) ? inst[24:20] : '0;

    always_ff @(posedge clk) begin
        if (wb_regf_we && wb_rd_s != '0) begin
            regs[wb_rd_s] <= wb_rd_v;
        end
    end

    always_comb begin
        if (rs1_s == '0) begin
            rs1_v = '0;
        end else if (fwd.id_rs1_sel == rv32i_pkg::id_sel_wb) begin
            rs1_v = wb_rd_v;
        end else begin
            rs1_v = regs[rs1_s];
        end
        if (rs2_s == '0) begin
            rs2_v = '0;
        end else if (fwd.id_rs2_sel == rv32i_pkg::id_sel_wb) begin
            rs2_v = wb_rd_v;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

    always_comb begin
        id_ex       = dec;
        id_ex.valid = ok && !fwd.stall;
        id_ex.pc    = if_id.pc;
        id_ex.rs1_s = rs1_s;
        id_ex.rs2_s = rs2_s;
        id_ex.rs1_v = rs1_v;
        id_ex.rs2_v = rs2_v;
        id_ex.rd    = inst[11:7];
        // a bubble carries no side effects downstream
        if (!id_ex.valid) begin
            id_ex.rd_we    = 1'b0;
            id_ex.is_load  = 1'b0;
            id_ex.is_store = 1'b0;
        end
    end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    input  rv32i_pkg::id_ex_t  id_ex,
    input  rv32i_pkg::ex_mem_t ex_mem_cur,
    input  rv32i_pkg::word_t   wb_rd_v,
    fwd_if.ex                  fwd,
    output rv32i_pkg::ex_mem_t ex_mem
);

    rv32i_pkg::word_t rs1_fwd;
    rv32i_pkg::word_t rs2_fwd;
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    rv32i_pkg::word_t result;

    function automatic rv32i_pkg::word_t pick(input rv32i_pkg::ex_fwd_sel_t sel,
                                              input rv32i_pkg::word_t id_v,
                                              input rv32i_pkg::word_t mem_v,
                                              input rv32i_pkg::word_t wb_v);
        case (sel)
            rv32i_pkg::ex_sel_mem: return mem_v;
            rv32i_pkg::ex_sel_wb:  return wb_v;
            default:               return id_v;
        endcase
    endfunction

    assign rs1_fwd = pick(fwd.ex_rs1_sel, id_ex.rs1_v, ex_mem_cur.alu, wb_rd_v);
    assign rs2_fwd = pick(fwd.ex_rs2_sel, id_ex.rs2_v, ex_mem_cur.alu, wb_rd_v);

    assign a = id_ex.a_pc ? id_ex.pc : rs1_fwd;
    assign b = id_ex.b_imm ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.alu_op)
            rv32i_pkg::alu_add:    result = a + b;
            rv32i_pkg::alu_sub:    result = a - b;
            rv32i_pkg::alu_sll:    result = a << b[4:0];
            rv32i_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            rv32i_pkg::alu_sltu:   result = {31'b0, a < b};
            rv32i_pkg::alu_xor:    result = a ^ b;
            rv32i_pkg::alu_srl:    result = a >> b[4:0];
            rv32i_pkg::alu_sra:    result = $signed(a) >>> b[4:0];
            rv32i_pkg::alu_or:     result = a | b;
            rv32i_pkg::alu_and:    result = a & b;
            default:               result = b;
        endcase
    end

    assign ex_mem.valid      = id_ex.valid;
    assign ex_mem.alu        = result;
    assign ex_mem.store_data = rs2_fwd;
    assign ex_mem.rd         = id_ex.rd;
    assign ex_mem.rd_we      = id_ex.rd_we;
    assign ex_mem.is_load    = id_ex.is_load;
    assign ex_mem.is_store   = id_ex.is_store;

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  rv32i_pkg::ex_mem_t ex_mem,
    output rv32i_pkg::word_t   dmem_addr,
    output logic [3:0]         dmem_rmask,
    output logic [3:0]         dmem_wmask,
    output rv32i_pkg::word_t   dmem_wdata,
    output rv32i_pkg::mem_wb_t mem_wb
);

    // word accesses only, so the low address bits are dropped
    assign dmem_addr  = {ex_mem.alu[31:2], 2'b00};
    assign dmem_rmask = (ex_mem.valid && ex_mem.is_load) ? 4'hf : 4'h0;
    assign dmem_wmask = (ex_mem.valid && ex_mem.is_store) ? 4'hf : 4'h0;
    assign dmem_wdata = ex_mem.store_data;

    assign mem_wb.valid   = ex_mem.valid;
    assign mem_wb.alu     = ex_mem.alu;
    assign mem_wb.rd      = ex_mem.rd;
    assign mem_wb.rd_we   = ex_mem.rd_we;
    assign mem_wb.is_load = ex_mem.is_load;

endmodule

//--- src/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
    input  rv32i_pkg::mem_wb_t  mem_wb,
    input  logic                dmem_resp,
    input  rv32i_pkg::word_t    dmem_rdata,
    output rv32i_pkg::reg_idx_t wb_rd_s,
    output rv32i_pkg::word_t    wb_rd_v,
    output logic                wb_regf_we
);

    assign wb_rd_s = mem_wb.rd;
    assign wb_rd_v = mem_wb.is_load ? dmem_rdata : mem_wb.alu;

    // load data is only written once the data memory has answered
    assign wb_regf_we = mem_wb.valid && mem_wb.rd_we && (mem_wb.rd != '0)
                        && (!mem_wb.is_load || dmem_resp);

endmodule

//--- src/forwarding.sv
`timescale 1ns/1ns

module forwarding (
    input  rv32i_pkg::reg_idx_t rs1_s,
    input  rv32i_pkg::reg_idx_t rs2_s,
    input  rv32i_pkg::id_ex_t   id_ex,
    input  rv32i_pkg::ex_mem_t  ex_mem,
    input  rv32i_pkg::mem_wb_t  mem_wb,
    fwd_if.ctrl                 fwd
);

    logic mem_writes;
    logic wb_writes;

    assign mem_writes = ex_mem.valid && ex_mem.rd_we && (ex_mem.rd != '0);
    assign wb_writes  = mem_wb.valid && mem_wb.rd_we && (mem_wb.rd != '0);

    // the memory stage holds the newer result, so it wins over writeback
    function automatic rv32i_pkg::ex_fwd_sel_t ex_pick(input rv32i_pkg::reg_idx_t src,
                                                       input logic mem_hit_ok,
                                                       input rv32i_pkg::reg_idx_t mem_rd,
                                                       input logic wb_hit_ok,
                                                       input rv32i_pkg::reg_idx_t wb_rd);
        if (mem_hit_ok && mem_rd == src) begin
            return rv32i_pkg::ex_sel_mem;
        end else if (wb_hit_ok && wb_rd == src) begin
            return rv32i_pkg::ex_sel_wb;
        end
        return rv32i_pkg::ex_sel_id_ex;
    endfunction

    assign fwd.ex_rs1_sel = ex_pick(id_ex.rs1_s, mem_writes, ex_mem.rd, wb_writes, mem_wb.rd);
    assign fwd.ex_rs2_sel = ex_pick(id_ex.rs2_s, mem_writes, ex_mem.rd, wb_writes, mem_wb.rd);

    assign fwd.id_rs1_sel = (wb_writes && mem_wb.rd == rs1_s) ? rv32i_pkg::id_sel_wb
                                                               : rv32i_pkg::id_sel_regfile;
    assign fwd.id_rs2_sel = (wb_writes && mem_wb.rd == rs2_s) ? rv32i_pkg::id_sel_wb
                                                               : rv32i_pkg::id_sel_regfile;

    // a load in execute cannot feed the instruction right behind it
    assign fwd.stall = id_ex.valid && id_ex.is_load && (id_ex.rd != '0)
                       && ((id_ex.rd == rs1_s) || (id_ex.rd == rs2_s));

endmodule

//--- src/cpu.sv
`timescale 1ns/1ns

module cpu #(
    parameter rv32i_pkg::word_t reset_pc = '0
) (
    input  logic             clk,
    input  logic             rst,

    output rv32i_pkg::word_t imem_addr,
    output logic [3:0]       imem_rmask,
    input  rv32i_pkg::word_t imem_rdata,
    input  logic             imem_resp,

    output rv32i_pkg::word_t dmem_addr,
    output logic [3:0]       dmem_rmask,
    output logic [3:0]       dmem_wmask,
    input  rv32i_pkg::word_t dmem_rdata,
    output rv32i_pkg::word_t dmem_wdata,
    input  logic             dmem_resp
);

    rv32i_pkg::if_id_t   if_id_cur, if_id_next;
    rv32i_pkg::id_ex_t   id_ex_cur, id_ex_next;
    rv32i_pkg::ex_mem_t  ex_mem_cur, ex_mem_next;
    rv32i_pkg::mem_wb_t  mem_wb_cur, mem_wb_next;

    rv32i_pkg::reg_idx_t id_rs1_s;
    rv32i_pkg::reg_idx_t id_rs2_s;
    rv32i_pkg::reg_idx_t wb_rd_s;
    rv32i_pkg::word_t    wb_rd_v;
    logic                wb_regf_we;
    logic                pc_en;

    fwd_if fwd ();

    assign pc_en = ~fwd.stall;

    forwarding u_forwarding (
        .rs1_s  (id_rs1_s),
        .rs2_s  (id_rs2_s),
        .id_ex  (id_ex_cur),
        .ex_mem (ex_mem_cur),
        .mem_wb (mem_wb_cur),
        .fwd    (fwd.ctrl)
    );

    if_stage #(
        .reset_pc (reset_pc)
    ) u_if_stage (
        .clk        (clk),
        .rst        (rst),
        .pc_en      (pc_en),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .if_id      (if_id_next)
    );

    // fetch and decode both hold while a load-use bubble is inserted
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_cur <= '0;
        end else if (pc_en) begin
            if_id_cur <= if_id_next;
        end
    end

    id_stage u_id_stage (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id_cur),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .wb_rd_s    (wb_rd_s),
        .wb_rd_v    (wb_rd_v),
        .wb_regf_we (wb_regf_we),
        .rs1_s      (id_rs1_s),
        .rs2_s      (id_rs2_s),
        .fwd        (fwd.id),
        .id_ex      (id_ex_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_cur <= '0;
        end else begin
            id_ex_cur <= id_ex_next;
        end
    end

    ex_stage u_ex_stage (
        .id_ex      (id_ex_cur),
        .ex_mem_cur (ex_mem_cur),
        .wb_rd_v    (wb_rd_v),
        .fwd        (fwd.ex),
        .ex_mem     (ex_mem_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_cur <= '0;
        end else begin
            ex_mem_cur <= ex_mem_next;
        end
    end

    mem_stage u_mem_stage (
        .ex_mem     (ex_mem_cur),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .mem_wb     (mem_wb_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_cur <= '0;
        end else begin
            mem_wb_cur <= mem_wb_next;
        end
    end

    wb_stage u_wb_stage (
        .mem_wb     (mem_wb_cur),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .wb_rd_s    (wb_rd_s),
        .wb_rd_v    (wb_rd_v),
        .wb_regf_we (wb_regf_we)
    );

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

    localparam int          max_cycles     = 2000;
    localparam logic [31:0] reset_pc_value = 32'h0000_0000;
    localparam logic [31:0] sentinel_addr  = 32'h0000_00fc;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_rdata;
    logic [31:0] dmem_wdata;
    logic        dmem_resp;

    logic [31:0] stim [0:255];
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int   mismatches      = 0;
    int   other_errors    = 0;
    int   stores_seen     = 0;
    int   released_cycles;
    logic fetch_seen;
    logic sentinel_seen   = 1'b0;
    logic finished_ok;

    cpu #(
        .reset_pc (reset_pc_value)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_resp  (dmem_resp)
    );

    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        stores_seen++;
        assert (exp_addr.size() != 0) else begin
            other_errors++;
            $display("store %0d to address %h was not in the expected list", stores_seen, addr);
        end
        if (exp_addr.size() != 0) begin
            compare_value("dmem_addr", addr, exp_addr.pop_front());
            compare_value("dmem_wdata", data, exp_data.pop_front());
        end
        if (addr == sentinel_addr) begin
            sentinel_seen = 1'b1;
        end
    endtask

    task automatic load_program;
        int i;
        int n_inst;
        int n_store;
        int pos;
        $readmemh("tests/cpu_stim.mem", stim);
        // unused words decode as addi x0, x0, index so a stray fetch changes no state
        for (i = 0; i < 256; i++) begin
            imem[i[7:0]] = {i[11:0], 20'h00013};
        end
        for (i = 0; i < 64; i++) begin
            dmem[i[5:0]] = 32'hd000_0000 | (i << 2);
        end
        n_inst = stim[0];
        assert (n_inst > 0 && n_inst < 200) else begin
            other_errors++;
            $display("the stimulus file holds no usable instruction count");
            n_inst = 0;
        end
        for (i = 0; i < n_inst; i++) begin
            pos = i + 1;
            imem[i[7:0]] = stim[pos[7:0]];
        end
        pos = n_inst + 1;
        n_store = stim[pos[7:0]];
        for (i = 0; i < n_store; i++) begin
            pos = n_inst + 2 + 2 * i;
            exp_addr.push_back(stim[pos[7:0]]);
            exp_data.push_back(stim[pos[7:0] + 8'd1]);
        end
    endtask

    task automatic wait_for_sentinel(output logic ok);
        int cycles;
        cycles = 0;
        while (!sentinel_seen && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        ok = sentinel_seen;
    endtask

    // instruction memory answers every request one cycle later
    always @(posedge clk) begin
        if (imem_rmask != 4'h0) begin
            imem_rdata <= imem[imem_addr[9:2]];
            imem_resp  <= 1'b1;
        end else begin
            imem_resp <= 1'b0;
        end
    end

    // the data memory returns loads next cycle and commits stores on the wmask cycle
    always @(posedge clk) begin
        dmem_resp <= 1'b0;
        if (dmem_rmask != 4'h0) begin
            dmem_rdata <= dmem[dmem_addr[7:2]];
            dmem_resp  <= 1'b1;
        end
        if (dmem_wmask != 4'h0) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
            check_store(dmem_addr, dmem_wdata);
        end
    end

    // nothing can reach the memory stage within three cycles of release
    always @(posedge clk) begin
        compare_value("imem_rmask", {28'h0, imem_rmask}, rst ? 32'h0 : 32'hf);
        if (rst || released_cycles < 3) begin
            compare_value("dmem_rmask", {28'h0, dmem_rmask}, 32'h0);
            compare_value("dmem_wmask", {28'h0, dmem_wmask}, 32'h0);
        end
        if (!rst && imem_rmask != 4'h0 && !fetch_seen) begin
            compare_value("imem_addr", imem_addr, reset_pc_value);
        end
        if (rst) begin
            released_cycles <= 0;
            fetch_seen      <= 1'b0;
        end else begin
            released_cycles <= released_cycles + 1;
            if (imem_rmask != 4'h0) begin
                fetch_seen <= 1'b1;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        imem_rdata = 32'h0;
        imem_resp  = 1'b0;
        dmem_rdata = 32'h0;
        dmem_resp  = 1'b0;
        load_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait_for_sentinel(finished_ok);
        assert (finished_ok) else begin
            other_errors++;
            $display("timeout: no store to the sentinel address within %0d cycles", max_cycles);
        end
        assert (exp_addr.size() == 0) else begin
            other_errors++;
            $display("%0d expected stores never arrived", exp_addr.size());
        end
        $display("checks done: %0d mismatches, %0d other errors, %0d stores seen",
                 mismatches, other_errors, stores_seen);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tests/cpu_stim.mem
// word 0: instruction count, then one program word per line
// after the program: store count, then pairs of store address and store data
00000025
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
002081b3 // add  x3, x1, x2
00302023 // sw   x3, 0(x0)
40208233 // sub  x4, x1, x2
00402223 // sw   x4, 4(x0)
0020c2b3 // xor  x5, x1, x2
00502423 // sw   x5, 8(x0)
00112333 // slt  x6, x2, x1
001133b3 // sltu x7, x2, x1
00109433 // sll  x8, x1, x1
40115493 // srai x9, x2, 1
01c15513 // srli x10, x2, 28
00602623 // sw   x6, 12(x0)
00702823 // sw   x7, 16(x0)
00802a23 // sw   x8, 20(x0)
00902c23 // sw   x9, 24(x0)
00a02e23 // sw   x10, 28(x0)
123455b7 // lui  x11, 0x12345
6785e593 // ori  x11, x11, 0x678
00001617 // auipc x12, 1
0ff5f693 // andi x13, x11, 0xff
02b02023 // sw   x11, 32(x0)
02c02223 // sw   x12, 36(x0)
02d02423 // sw   x13, 40(x0)
00402703 // lw   x14, 4(x0)
06470793 // addi x15, x14, 100
02f02623 // sw   x15, 44(x0)
07b00013 // addi x0, x0, 123
00100833 // add  x16, x0, x1
02002823 // sw   x0, 48(x0)
03002a23 // sw   x16, 52(x0)
0020e8b3 // or   x17, x1, x2
0020f933 // and  x18, x1, x2
03102c23 // sw   x17, 56(x0)
03202e23 // sw   x18, 60(x0)
0e102e23 // sw   x1, 252(x0), sentinel
00000011
00000000 00000002
00000004 00000008
00000008 fffffff8
0000000c 00000001
00000010 00000000
00000014 000000a0
00000018 fffffffe
0000001c 0000000f
00000020 12345678
00000024 00001050
00000028 00000078
0000002c 0000006c
00000030 00000000
00000034 00000005
00000038 fffffffd
0000003c 00000005
000000fc 00000005

//--- flist.f
src/rv32i_pkg.sv
src/fwd_if.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/mem_stage.sv
src/wb_stage.sv
src/forwarding.sv
src/cpu.sv
tests/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= tests/cpu_stim.mem
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN) $(STIM)
	-$(BIN) > $(LOG) 2>&1
	@if grep -q "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
